/* sim.f */
+incdir+rtl
rtl/mat_inv_pkg.sv
rtl/fxp_div.sv
rtl/lu_decomp.sv
rtl/tri_inv.sv
rtl/mat_inv.sv
rtl/inv_mul.sv
rtl/mat_inv_top.sv
dv/tb_mat_inv.sv

/* run.sh */
#!/bin/sh
# Build and run the matrix inverse testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sim.f --top-module tb_mat_inv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_mat_inv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

/* dv/tb_mat_inv.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module tb_mat_inv;

    import mat_inv_pkg::*;

    localparam int N          = `MI_MATSIZE;
    localparam int CLK_NS     = 4;
    localparam int MAX_MATS   = 40;
    localparam int MAT_CYCLES = 600;
    localparam int N_RANDOM   = 30;

    logic   clk;
    logic   rst_n;
    logic   en;
    logic   vld;
    lanes_t mat_in;
    logic   rdy;
    logic   vld_out;
    lanes_t mat_inv_out_l;
    lanes_t mat_inv_out_u;
    lanes_t mat_inv_out;

    integer seed      = 32'h451e59bf;
    int     errors    = 0;
    int     checks    = 0;
    int     n_accepted = 0;
    int     n_results = 0;
    logic   jitter_on = 1'b0;
    logic   vld_prev  = 1'b0;
    logic   en_prev   = 1'b1;
    lanes_t cap_l     = '0;
    lanes_t cap_u     = '0;
    lanes_t exp_l_q[$];
    lanes_t exp_u_q[$];
    lanes_t exp_i_q[$];

    mat_inv_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .vld           (vld),
        .mat_in        (mat_in),
        .rdy           (rdy),
        .vld_out       (vld_out),
        .mat_inv_out_l (mat_inv_out_l),
        .mat_inv_out_u (mat_inv_out_u),
        .mat_inv_out   (mat_inv_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ############################################################
    // Reference model
    // ############################################################

    function automatic fxp_t mul_trunc(input fxp_t a, input fxp_t b);
        longint p;
        p = longint'(a) * longint'(b);
        p = p >>> `MI_FRAC_BITS;                 // Floor of the scaled product
        return p[`MI_DATA_WIDTH-1:0];
    endfunction

    function automatic fxp_t div_trunc(input fxp_t n, input fxp_t d);
        longint q;
        q = (longint'(n) <<< `MI_FRAC_BITS) / longint'(d);  // Rounds toward zero
        return q[`MI_DATA_WIDTH-1:0];
    endfunction

    function automatic mat_t invert_upper(input mat_t t);
        mat_t x;
        fxp_t s;
        x = '0;
        for (int i = 0; i < N; i++) begin
            x[i][i] = div_trunc(fxp_one, t[i][i]);
        end
        for (int j = 1; j < N; j++) begin
            for (int i = j - 1; i >= 0; i--) begin
                s = '0;
                for (int m = i + 1; m <= j; m++) begin
                    s = s + mul_trunc(t[i][m], x[m][j]);
                end
                x[i][j] = -div_trunc(s, t[i][i]);
            end
        end
        return x;
    endfunction

    function automatic void ref_inverse(input lanes_t a_l, output lanes_t linv_l,
                                        output lanes_t uinv_l, output lanes_t inv_l);
        mat_t a;
        mat_t l;
        mat_t u;
        mat_t lt;
        mat_t uinv;
        mat_t ltinv;
        fxp_t s;
        l = '0;
        u = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a[r][c] = a_l[N*c+r];
            end
        end
        for (int k = 0; k < N; k++) begin
            for (int j = k; j < N; j++) begin
                s = a[k][j];
                for (int m = 0; m < k; m++) begin
                    s = s - mul_trunc(l[k][m], u[m][j]);
                end
                u[k][j] = s;
            end
            l[k][k] = fxp_one;
            for (int i = k + 1; i < N; i++) begin
                s = a[i][k];
                for (int m = 0; m < k; m++) begin
                    s = s - mul_trunc(l[i][m], u[m][k]);
                end
                l[i][k] = div_trunc(s, u[k][k]);
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                lt[r][c] = l[c][r];
            end
        end
        uinv  = invert_upper(u);
        ltinv = invert_upper(lt);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                s = '0;
                for (int m = 0; m < N; m++) begin
                    s = s + mul_trunc(uinv[r][m], ltinv[c][m]);  // inv(L)[m][c]
                end
                inv_l[N*c+r]  = s;
                uinv_l[N*c+r] = uinv[r][c];
                linv_l[N*c+r] = ltinv[c][r];
            end
        end
    endfunction

    // ############################################################
    // Stimulus helpers
    // ############################################################

    task automatic check_lanes(input string name, input lanes_t exp, input lanes_t got);
        for (int n = 0; n < `MI_LANES; n++) begin
            checks++;
            if (got[n] !== exp[n]) begin
                errors++;
                $display("** Error: %s[%0d] expected %h got %h", name, n, exp[n], got[n]);
            end
        end
    endtask

    task automatic random_matrix(output lanes_t m);
        fxp_t d;
        for (int c = 0; c < N; c++) begin
            for (int r = 0; r < N; r++) begin
                if (r == c) begin
                    d = 32'h40000 + ($random(seed) & 32'h3ffff);  // 4.0 up to 8.0
                    m[N*c+r] = ($random(seed) & 1) ? -d : d;
                end else begin
                    m[N*c+r] = $random(seed) % 65536;   // Below 1.0 in magnitude
                end
            end
        end
    endtask

    task automatic send_matrix(input lanes_t m);
        lanes_t el;
        lanes_t eu;
        lanes_t ei;
        logic   accepted;
        accepted = 1'b0;
        ref_inverse(m, el, eu, ei);
        @(negedge clk);
        while (!rdy) @(negedge clk);
        vld    = 1'b1;
        mat_in = m;
        while (!accepted) begin
            @(posedge clk);
            accepted = en && rdy;
        end
        exp_l_q.push_back(el);
        exp_u_q.push_back(eu);
        exp_i_q.push_back(ei);
        n_accepted++;
        @(negedge clk);
        vld = 1'b0;
        if (rdy) begin
            errors++;
            $display("rdy did not fall after a matrix was accepted at %0t", $time);
        end
    endtask

    task automatic wait_results;
        while (n_results < n_accepted) @(posedge clk);
    endtask

    // Random en stretches while jitter_on is set
    initial begin
        int en_hold;
        en_hold = 0;
        en = 1'b1;
        forever begin
            @(negedge clk);
            if (!jitter_on) begin
                en = 1'b1;
            end else if (en_hold == 0) begin
                en      = !en;
                en_hold = en ? ($random(seed) & 15) + 1 : ($random(seed) & 7) + 1;
            end else begin
                en_hold--;
            end
        end
    end

    // ############################################################
    // Monitor and comparator
    // ############################################################

    always @(posedge clk) begin
        if (rst_n) begin
            if (uut.tri_vld && en) begin      // L and U inverses land one cycle early
                cap_l = mat_inv_out_l;
                cap_u = mat_inv_out_u;
            end
            if (vld_out && !vld_prev && !en_prev) begin
                errors++;
                $display("vld_out rose on an edge where en was low at %0t", $time);
            end
            if (vld_out && en) begin
                n_results++;
                if (exp_i_q.size() == 0) begin
                    errors++;
                    $display("Result appeared with no accepted matrix at %0t", $time);
                end else begin
                    check_lanes("mat_inv_out_l", exp_l_q.pop_front(), cap_l);
                    check_lanes("mat_inv_out_u", exp_u_q.pop_front(), cap_u);
                    check_lanes("mat_inv_out", exp_i_q.pop_front(), mat_inv_out);
                end
            end
        end
        vld_prev = vld_out;
        en_prev  = en;
    end

    initial begin
        #(MAX_MATS * MAT_CYCLES * CLK_NS);
        $display("Timeout with %0d of %0d results received", n_results, n_accepted);
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("Testbench failed");
        $finish;
    end

    // ############################################################
    // Test sequence
    // ############################################################

    initial begin
        lanes_t m;
        lanes_t other;
        rst_n  = 1'b0;
        vld    = 1'b0;
        mat_in = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (rdy !== 1'b1 || vld_out !== 1'b0) begin
            errors++;
            $display("** Error: rdy/vld_out after reset expected 1/0 got %h/%h", rdy, vld_out);
        end
        check_lanes("mat_inv_out_l", '0, mat_inv_out_l);
        check_lanes("mat_inv_out_u", '0, mat_inv_out_u);
        check_lanes("mat_inv_out", '0, mat_inv_out);

        m    = '0;                                // Identity
        m[0] = fxp_one;
        m[4] = fxp_one;
        m[8] = fxp_one;
        send_matrix(m);
        wait_results();
        m[0] = 32'h0002_0000;                     // diag(2, 4, 0.5)
        m[4] = 32'h0004_0000;
        m[8] = 32'h0000_8000;
        send_matrix(m);
        wait_results();

        for (int n = 0; n < N_RANDOM; n++) begin
            random_matrix(m);
            send_matrix(m);
            wait_results();
        end

        // Second matrix offered while busy must be dropped
        random_matrix(m);
        random_matrix(other);
        send_matrix(m);
        vld    = 1'b1;
        mat_in = other;
        repeat (20) begin
            @(negedge clk);
            if (rdy) begin
                errors++;
                $display("rdy rose while a matrix was still in progress at %0t", $time);
            end
        end
        vld    = 1'b0;
        mat_in = '0;
        wait_results();

        repeat (2) begin
            random_matrix(m);
            jitter_on = 1'b1;
            send_matrix(m);
            wait_results();
            jitter_on = 1'b0;
        end

        repeat (20) @(posedge clk);               // Room for a stray extra result
        if (n_results != n_accepted || exp_i_q.size() != 0) begin
            errors++;
            $display("Result count mismatch: %0d accepted, %0d returned", n_accepted, n_results);
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* rtl/mat_inv_top.sv */
`timescale 1ns/1ps

module mat_inv_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                vld,
    input  mat_inv_pkg::lanes_t mat_in,
    output logic                rdy,
    output logic                vld_out,
    output mat_inv_pkg::lanes_t mat_inv_out_l,
    output mat_inv_pkg::lanes_t mat_inv_out_u,
    output mat_inv_pkg::lanes_t mat_inv_out
);

    import mat_inv_pkg::*;

    mat_t u_inv;
    mat_t l_inv;
    logic tri_vld;                   // L and U inverses published

    mat_inv u_mat_inv (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .vld           (vld),
        .mat_in        (mat_in),
        .rdy           (rdy),
        .vld_out       (tri_vld),
        .mat_inv_out_l (mat_inv_out_l),
        .mat_inv_out_u (mat_inv_out_u),
        .u_inv_mat     (u_inv),
        .l_inv_mat     (l_inv)
    );

    inv_mul u_inv_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .vld       (tri_vld),
        .u_inv_mat (u_inv),
        .l_inv_mat (l_inv),
        .mat_out   (mat_inv_out),
        .vld_out   (vld_out)
    );

endmodule

/* rtl/inv_mul.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module inv_mul (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                vld,
    input  mat_inv_pkg::mat_t   u_inv_mat,
    input  mat_inv_pkg::mat_t   l_inv_mat,
    output mat_inv_pkg::lanes_t mat_out,
    output logic                vld_out
);

    import mat_inv_pkg::*;

    localparam int N = `MI_MATSIZE;

    lanes_t prod_lanes;

    // inv(A) = inv(U) * inv(L), written straight into column-major lanes
    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                prod_lanes[N*j+i] = '0;
                for (int m = 0; m < N; m++) begin
                    prod_lanes[N*j+i] = prod_lanes[N*j+i]
                                      + fxp_mul(u_inv_mat[i][m], l_inv_mat[m][j]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mat_out <= '0;
            vld_out <= 1'b0;
        end else if (en) begin
            vld_out <= vld;
            if (vld) begin
                mat_out <= prod_lanes;
            end
        end
    end

endmodule

/* rtl/mat_inv.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module mat_inv (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                vld,
    input  mat_inv_pkg::lanes_t mat_in,
    output logic                rdy,
    output logic                vld_out,
    output mat_inv_pkg::lanes_t mat_inv_out_l,
    output mat_inv_pkg::lanes_t mat_inv_out_u,
    output mat_inv_pkg::mat_t   u_inv_mat,
    output mat_inv_pkg::mat_t   l_inv_mat
);

    import mat_inv_pkg::*;

    localparam int N = `MI_MATSIZE;

    typedef enum logic [1:0] {S_IDLE, S_LU, S_TRI, S_PUB} state_t;

    state_t state;
    mat_t   mat_in_m;
    mat_t   a_r;
    mat_t   l_mat;
    mat_t   u_mat;
    mat_t   l_t;
    mat_t   u_inv;
    mat_t   lt_inv;
    mat_t   l_inv;
    logic   lu_start;
    logic   lu_done;
    logic   tri_start;
    logic   u_done;
    logic   lt_done;
    logic   u_done_f;
    logic   lt_done_f;

    // ############################################################
    // Lane mapping and transposes
    // ############################################################

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            assign mat_in_m[r][c]          = mat_in[N*c+r];
            assign l_t[r][c]               = l_mat[c][r];
            assign l_inv[r][c]             = lt_inv[c][r];  // inv(L^T)^T = inv(L)
            assign mat_inv_out_u[N*c+r]    = u_inv_mat[r][c];
            assign mat_inv_out_l[N*c+r]    = l_inv_mat[r][c];
        end
    end

    assign rdy = (state == S_IDLE);

    // ############################################################
    // Sequencer
    // ############################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            lu_start  <= 1'b0;
            tri_start <= 1'b0;
            u_done_f  <= 1'b0;
            lt_done_f <= 1'b0;
            vld_out   <= 1'b0;
            u_inv_mat <= '0;
            l_inv_mat <= '0;
        end else if (en) begin
            lu_start  <= 1'b0;
            tri_start <= 1'b0;
            vld_out   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (vld) begin
                        lu_start <= 1'b1;
                        state    <= S_LU;
                    end
                end
                S_LU: begin
                    if (lu_done) begin
                        tri_start <= 1'b1;
                        u_done_f  <= 1'b0;
                        lt_done_f <= 1'b0;
                        state     <= S_TRI;
                    end
                end
                S_TRI: begin
                    if (u_done) begin
                        u_done_f <= 1'b1;
                    end
                    if (lt_done) begin
                        lt_done_f <= 1'b1;
                    end
                    if ((u_done_f || u_done) && (lt_done_f || lt_done)) begin
                        state <= S_PUB;
                    end
                end
                S_PUB: begin
                    u_inv_mat <= u_inv;
                    l_inv_mat <= l_inv;
                    vld_out   <= 1'b1;
                    state     <= S_IDLE;
                end
            endcase
        end
    end

    // Input held for the whole factorisation
    always_ff @(posedge clk) begin
        if (en && vld && state == S_IDLE) begin
            a_r <= mat_in_m;
        end
    end

    // ############################################################
    // Factorisation and triangular inverses
    // ############################################################

    lu_decomp u_lu (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .start (lu_start),
        .a_mat (a_r),
        .l_mat (l_mat),
        .u_mat (u_mat),
        .done  (lu_done)
    );

    tri_inv tri_inv_u (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .start   (tri_start),
        .t_mat   (u_mat),
        .inv_out (u_inv),
        .done    (u_done)
    );

    tri_inv tri_inv_lt (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .start   (tri_start),
        .t_mat   (l_t),
        .inv_out (lt_inv),
        .done    (lt_done)
    );

endmodule

/* rtl/tri_inv.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module tri_inv (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  logic              start,
    input  mat_inv_pkg::mat_t t_mat,
    output mat_inv_pkg::mat_t inv_out,
    output logic              done
);

    import mat_inv_pkg::*;

    localparam int N = `MI_MATSIZE;

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_t;

    state_t     state;
    logic [1:0] i;
    logic [1:0] j;
    mat_t       x_w;
    fxp_t       sum;
    fxp_t       div_num;
    fxp_t       div_den;
    fxp_t       div_q;
    logic       div_start;
    logic       div_done;
    logic       last;

    assign inv_out = x_w;

    // Diagonal first, then columns left to right, rows bottom up
    assign last = (i == 2'd0) && (j == 2'(N-1));

    always_comb begin
        sum = '0;
        for (int m = 0; m < N; m++) begin
            if (m > int'(i) && m <= int'(j)) begin
                sum = sum + fxp_mul(t_mat[i][m], x_w[m][j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            i         <= '0;
            j         <= '0;
            div_start <= 1'b0;
            done      <= 1'b0;
        end else if (en) begin
            div_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        i     <= '0;
                        j     <= '0;
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    div_start <= 1'b1;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    if (div_done) begin
                        if (last) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            state <= S_ISSUE;
                            if (i == j) begin
                                if (i == 2'(N-1)) begin  // Diagonal finished
                                    i <= '0;
                                    j <= 2'd1;
                                end else begin
                                    i <= i + 1'b1;
                                    j <= j + 1'b1;
                                end
                            end else if (i != 2'd0) begin
                                i <= i - 1'b1;
                            end else begin
                                i <= j;               // Just above the next diagonal
                                j <= j + 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (state == S_IDLE && start) begin
                x_w <= '0;
            end
            if (state == S_ISSUE) begin
                div_num <= (i == j) ? fxp_one : sum;
                div_den <= t_mat[i][i];
            end
            if (state == S_WAIT && div_done) begin
                x_w[i][j] <= (i == j) ? div_q : -div_q;
            end
        end
    end

    fxp_div u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .start    (div_start),
        .dividend (div_num),
        .divisor  (div_den),
        .quotient (div_q),
        .done     (div_done)
    );

endmodule

/* rtl/lu_decomp.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module lu_decomp (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  logic              start,
    input  mat_inv_pkg::mat_t a_mat,
    output mat_inv_pkg::mat_t l_mat,
    output mat_inv_pkg::mat_t u_mat,
    output logic              done
);

    import mat_inv_pkg::*;

    localparam int N = `MI_MATSIZE;

    typedef enum logic [1:0] {S_IDLE, S_ROW, S_DIV, S_WAIT} state_t;

    state_t       state;
    logic [1:0]   k;                 // Pivot
    logic [1:0]   i;                 // Row of the L element being divided
    mat_t         l_w;
    mat_t         u_w;
    fxp_t [N-1:0] row_u;
    fxp_t         l_num;
    fxp_t         div_num;
    fxp_t         div_den;
    fxp_t         div_q;
    logic         div_start;
    logic         div_done;

    assign l_mat = l_w;
    assign u_mat = u_w;

    // Row k of U and the numerator of l[i][k], sums in ascending m
    always_comb begin
        for (int j = 0; j < N; j++) begin
            row_u[j] = a_mat[k][j];
            for (int m = 0; m < N; m++) begin
                if (m < int'(k)) begin
                    row_u[j] = row_u[j] - fxp_mul(l_w[k][m], u_w[m][j]);
                end
            end
        end
        l_num = a_mat[i][k];
        for (int m = 0; m < N; m++) begin
            if (m < int'(k)) begin
                l_num = l_num - fxp_mul(l_w[i][m], u_w[m][k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            k         <= '0;
            i         <= '0;
            div_start <= 1'b0;
            done      <= 1'b0;
        end else if (en) begin
            div_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        k     <= '0;
                        state <= S_ROW;
                    end
                end
                S_ROW: begin
                    if (k == 2'(N-1)) begin  // Last pivot has no L below it
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        i     <= k + 1'b1;
                        state <= S_DIV;
                    end
                end
                S_DIV: begin
                    div_start <= 1'b1;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    if (div_done) begin
                        if (i == 2'(N-1)) begin
                            k     <= k + 1'b1;
                            state <= S_ROW;
                        end else begin
                            i     <= i + 1'b1;
                            state <= S_DIV;
                        end
                    end
                end
            endcase
        end
    end

    // Working L and U, updated in place
    always_ff @(posedge clk) begin
        if (en) begin
            if (state == S_IDLE && start) begin
                l_w <= '0;
                u_w <= '0;
            end
            if (state == S_ROW) begin
                for (int j = 0; j < N; j++) begin
                    if (j >= int'(k)) begin
                        u_w[k][j] <= row_u[j];
                    end
                end
                l_w[k][k] <= fxp_one;
            end
            if (state == S_DIV) begin
                div_num <= l_num;
                div_den <= u_w[k][k];
            end
            if (state == S_WAIT && div_done) begin
                l_w[i][k] <= div_q;
            end
        end
    end

    fxp_div u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .start    (div_start),
        .dividend (div_num),
        .divisor  (div_den),
        .quotient (div_q),
        .done     (div_done)
    );

endmodule

/* rtl/fxp_div.sv */
`timescale 1ns/1ps
`include "mat_inv_defs.svh"

module fxp_div (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  logic              start,
    input  mat_inv_pkg::fxp_t dividend,
    input  mat_inv_pkg::fxp_t divisor,
    output mat_inv_pkg::fxp_t quotient,
    output logic              done
);

    localparam int W     = `MI_DATA_WIDTH;
    localparam int FRAC  = `MI_FRAC_BITS;
    localparam int EXT_W = `MI_DATA_WIDTH + `MI_FRAC_BITS;

    logic             busy;
    logic [5:0]       cnt;
    logic [EXT_W-1:0] dvd;           // Dividend bits shift out, quotient bits in
    logic [W-1:0]     dvs;
    logic [W-1:0]     rem;
    logic             neg;
    logic [W:0]       rem_sh;
    logic             fits;
    logic [W-1:0]     dividend_mag;
    logic [W-1:0]     divisor_mag;

    assign dividend_mag = dividend[W-1] ? -dividend : dividend;
    assign divisor_mag  = divisor[W-1] ? -divisor : divisor;

    assign rem_sh = {rem, dvd[EXT_W-1]};
    assign fits   = rem_sh >= {1'b0, dvs};  // Zero divisor always fits

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (en) begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == 6'(EXT_W)) begin  // Sign step
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // Restoring shift-subtract datapath, one quotient bit per cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (start) begin
                dvd <= {dividend_mag, {FRAC{1'b0}}};
                dvs <= divisor_mag;
                rem <= '0;
                neg <= dividend[W-1] ^ divisor[W-1];
            end else if (busy && cnt != 6'(EXT_W)) begin
                dvd <= {dvd[EXT_W-2:0], fits};
                rem <= fits ? rem_sh[W-1:0] - dvs : rem_sh[W-1:0];
            end else if (busy) begin
                quotient <= neg ? -dvd[W-1:0] : dvd[W-1:0];  // Low word only
            end
        end
    end

endmodule

/* rtl/mat_inv_pkg.sv */
`include "mat_inv_defs.svh"

package mat_inv_pkg;

    typedef logic signed [`MI_DATA_WIDTH-1:0] fxp_t;

    typedef fxp_t [`MI_MATSIZE-1:0][`MI_MATSIZE-1:0] mat_t;  // [row][col]

    typedef fxp_t [`MI_LANES-1:0] lanes_t;  // Lane 3*col+row

    localparam fxp_t fxp_one = fxp_t'(1 << `MI_FRAC_BITS);

    // Truncating Q16.16 multiply, floor of the scaled product
    function automatic fxp_t fxp_mul(input fxp_t a, input fxp_t b);
        logic signed [2*`MI_DATA_WIDTH-1:0] prod;
        logic signed [2*`MI_DATA_WIDTH-1:0] prod_sh;
        prod    = a * b;
        prod_sh = prod >>> `MI_FRAC_BITS;
        return prod_sh[`MI_DATA_WIDTH-1:0];
    endfunction

endpackage

/* rtl/mat_inv_defs.svh */
`ifndef MAT_INV_DEFS_SVH
`define MAT_INV_DEFS_SVH

// Element format is Q16.16 in a 32-bit word
`define MI_DATA_WIDTH 32
`define MI_FRAC_BITS  16

// Matrix order and number of external lanes
`define MI_MATSIZE    3
`define MI_LANES      (`MI_MATSIZE * `MI_MATSIZE)

`endif
